//--- verilog/pack_pkg.sv
package pack_pkg;

  // Default FIFO sizes, given as log2 of the entry count.
  localparam int IN_DEPTH_W = 4; // 16 byte entries.
  localparam int OUT_DEPTH_W = 2; // 4 word entries.

  localparam int WORD_BYTES = 4; // Bytes packed into one output word.

  // One byte of the input stream.
  typedef struct packed {
    logic [7:0] data;
    logic       last; // Final byte of its packet.
  } byte_beat_t;

  // One packed word of the output stream.
  typedef struct packed {
    logic [8*WORD_BYTES-1:0] data;   // Little-endian, byte 0 in bits 7:0.
    logic [2:0]              nbytes; // Valid bytes, 1 to 4, from the bottom up.
    logic                    last;   // Word closes a packet.
  } word_beat_t;

endpackage

//--- verilog/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
  parameter int fifo_depth_w = 4,
  parameter type data_t = logic [7:0]
) (
  input  logic  clk,
  input  logic  anrst,
  input  logic  nrst,
  input  data_t a_data,
  input  logic  a_valid,
  output logic  a_ready,
  output data_t b_data,
  output logic  b_valid,
  input  logic  b_ready
);

  localparam int ptr_w = (fifo_depth_w > 0) ? fifo_depth_w : 1;
  localparam int entries = 2 ** fifo_depth_w;
  // A single-entry FIFO keeps both pointers at zero.
  localparam logic [ptr_w-1:0] ptr_step = (fifo_depth_w > 0) ? ptr_w'(1) : '0;

  localparam logic [1:0] op_read = 2'b01;
  localparam logic [1:0] op_write = 2'b10;

  data_t            mem [0:entries-1];
  logic [ptr_w-1:0] read_pos;
  logic [ptr_w-1:0] read_pos_n;
  logic [ptr_w-1:0] write_pos;
  logic [ptr_w-1:0] write_pos_n;
  logic             full;
  logic             wr_en;
  logic             rd_en;
  logic [1:0]       op;
  logic             fall_through;

  assign a_ready = ~full;
  assign b_valid = (write_pos == read_pos) ? full : 1'b1; // Equal pointers mean empty or full.

  assign wr_en = a_valid & a_ready;
  assign rd_en = b_valid & b_ready;
  assign op = {wr_en, rd_en};

  always_comb begin
    write_pos_n = write_pos;
    read_pos_n = read_pos;
    if (wr_en) begin
      write_pos_n = write_pos + ptr_step;
    end
    if (rd_en) begin
      read_pos_n = read_pos + ptr_step;
    end
  end

  // The next head is the entry being written right now.
  // This covers a write into an empty FIFO and a read plus write with one entry held.
  assign fall_through = wr_en & (read_pos_n == write_pos);

  always_ff @(posedge clk, negedge anrst) begin
    if (~anrst) begin
      read_pos <= '0;
      write_pos <= '0;
    end else begin
      if (~nrst) begin
        read_pos <= '0;
        write_pos <= '0;
      end else begin
        read_pos <= read_pos_n;
        write_pos <= write_pos_n;
      end
    end
  end

  always_ff @(posedge clk, negedge anrst) begin
    if (~anrst) begin
      full <= 1'b0;
    end else begin
      if (~nrst) begin
        full <= 1'b0;
      end else begin
        case (op)
          op_read: begin
            full <= 1'b0; // Any read alone frees an entry.
          end
          op_write: begin
            if (write_pos_n == read_pos) begin
              full <= 1'b1; // Write pointer caught up with the read pointer.
            end
          end
          default: begin
            full <= full; // Idle, or read and write together.
          end
        endcase
      end
    end
  end

  // Storage and the registered head entry.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[write_pos] <= a_data;
    end
    if (fall_through) begin
      b_data <= a_data;
    end else begin
      b_data <= mem[read_pos_n];
    end
  end

endmodule

//--- verilog/byte_packer.sv
`timescale 1ns/1ps

module byte_packer (
  input  logic                 clk,
  input  logic                 anrst,
  input  logic                 nrst,
  input  pack_pkg::byte_beat_t byte_data,
  input  logic                 byte_valid,
  output logic                 byte_ready,
  output pack_pkg::word_beat_t word_data,
  output logic                 word_valid,
  input  logic                 word_ready
);

  import pack_pkg::*;

  localparam int idx_w = $clog2(WORD_BYTES);
  localparam logic [idx_w-1:0] idx_top = idx_w'(WORD_BYTES - 1);

  logic [WORD_BYTES-2:0][7:0] part;  // Bytes collected so far.
  logic [idx_w-1:0]           idx;   // Lane of the next byte.
  logic [WORD_BYTES-1:0][7:0] lanes;
  word_beat_t                 next_word;
  logic                       take;
  logic                       word_done;

  // Stall only while a finished word waits and nobody takes it.
  assign byte_ready = ~word_valid | word_ready;
  assign take = byte_valid & byte_ready;
  assign word_done = take & (byte_data.last | (idx == idx_top));

  // Word as it would be with the current byte in place, zeros above it.
  always_comb begin
    lanes = '0;
    for (int i = 0; i < WORD_BYTES - 1; i++) begin
      if (i < int'(idx)) begin
        lanes[i] = part[i];
      end
    end
    lanes[idx] = byte_data.data;
    next_word.data = lanes;
    next_word.nbytes = 3'(idx) + 3'd1;
    next_word.last = byte_data.last;
  end

  always_ff @(posedge clk, negedge anrst) begin
    if (~anrst) begin
      idx <= '0;
      word_valid <= 1'b0;
    end else begin
      if (~nrst) begin
        idx <= '0;
        word_valid <= 1'b0;
      end else begin
        if (word_done) begin
          idx <= '0;
          word_valid <= 1'b1; // Replaces a word that leaves on this edge.
        end else begin
          if (take) begin
            idx <= idx + 1'b1;
          end
          if (word_ready) begin
            word_valid <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take & ~word_done) begin
      part[idx] <= byte_data.data;
    end
    if (word_done) begin
      word_data <= next_word;
    end
  end

endmodule

//--- verilog/pack_top.sv
`timescale 1ns/1ps

module pack_top #(
  parameter int in_depth_w = pack_pkg::IN_DEPTH_W,
  parameter int out_depth_w = pack_pkg::OUT_DEPTH_W
) (
  input  logic        clk,
  input  logic        anrst,
  input  logic        nrst,
  input  logic [7:0]  in_data,
  input  logic        in_last,
  input  logic        in_valid,
  output logic        in_ready,
  output logic [31:0] out_data,
  output logic [2:0]  out_nbytes,
  output logic        out_last,
  output logic        out_valid,
  input  logic        out_ready
);

  import pack_pkg::*;

  byte_beat_t in_beat;
  byte_beat_t b_data;
  logic       b_valid;
  logic       b_ready;
  word_beat_t word_data;
  logic       word_valid;
  logic       word_ready;
  word_beat_t out_beat;

  assign in_beat = '{data: in_data, last: in_last};

  stream_fifo #(
    .fifo_depth_w(in_depth_w),
    .data_t(byte_beat_t)
  ) u_in_fifo (
    .clk(clk),
    .anrst(anrst),
    .nrst(nrst),
    .a_data(in_beat),
    .a_valid(in_valid),
    .a_ready(in_ready),
    .b_data(b_data),
    .b_valid(b_valid),
    .b_ready(b_ready)
  );

  byte_packer u_packer (
    .clk(clk),
    .anrst(anrst),
    .nrst(nrst),
    .byte_data(b_data),
    .byte_valid(b_valid),
    .byte_ready(b_ready),
    .word_data(word_data),
    .word_valid(word_valid),
    .word_ready(word_ready)
  );

  stream_fifo #(
    .fifo_depth_w(out_depth_w),
    .data_t(word_beat_t)
  ) u_out_fifo (
    .clk(clk),
    .anrst(anrst),
    .nrst(nrst),
    .a_data(word_data),
    .a_valid(word_valid),
    .a_ready(word_ready),
    .b_data(out_beat),
    .b_valid(out_valid),
    .b_ready(out_ready)
  );

  assign out_data = out_beat.data;
  assign out_nbytes = out_beat.nbytes;
  assign out_last = out_beat.last;

endmodule

//--- dv/pack_checker.sv
`timescale 1ns/1ps

module pack_checker (
  input logic        clk,
  input logic        anrst,
  input logic        nrst,
  input logic [7:0]  in_data,
  input logic        in_last,
  input logic        in_valid,
  input logic        in_ready,
  input logic [31:0] out_data,
  input logic [2:0]  out_nbytes,
  input logic        out_last,
  input logic        out_valid,
  input logic        out_ready
);

  // A synchronous clear may drop a pending beat.
  property in_held;
    @(posedge clk) disable iff (~anrst)
      (in_valid & ~in_ready & nrst) |=>
        (~nrst | (in_valid & $stable(in_data) & $stable(in_last)));
  endproperty

  property out_held;
    @(posedge clk) disable iff (~anrst)
      (out_valid & ~out_ready & nrst) |=>
        (~nrst | (out_valid & $stable(out_data) & $stable(out_nbytes) & $stable(out_last)));
  endproperty

  property nbytes_range;
    @(posedge clk) disable iff (~anrst)
      out_valid |-> (out_nbytes >= 3'd1 && out_nbytes <= 3'd4);
  endproperty

  assert property (in_held) else $error("Input beat changed while stalled.");
  assert property (out_held) else $error("Output beat changed while stalled.");
  assert property (nbytes_range) else $error("Output byte count out of range.");

endmodule

bind pack_top pack_checker u_checker (
  .clk(clk),
  .anrst(anrst),
  .nrst(nrst),
  .in_data(in_data),
  .in_last(in_last),
  .in_valid(in_valid),
  .in_ready(in_ready),
  .out_data(out_data),
  .out_nbytes(out_nbytes),
  .out_last(out_last),
  .out_valid(out_valid),
  .out_ready(out_ready)
);

//--- dv/pack_tb.sv
`timescale 1ns/1ps

module pack_tb;

  import pack_pkg::*;

  localparam int mode_bp = 1;
  localparam int mode_clear = 2;
  localparam int mode_random = 3;
  localparam int word_wait = 100; // Idle cycles allowed between two output words.

  logic        clk;
  logic        anrst;
  logic        nrst;
  logic [7:0]  in_data;
  logic        in_last;
  logic        in_valid;
  logic        in_ready;
  logic [31:0] out_data;
  logic [2:0]  out_nbytes;
  logic        out_last;
  logic        out_valid;
  logic        out_ready;

  string       rec_kind [$]; // One entry per pattern line.
  string       rec_name [$];
  logic [31:0] rec_a [$];
  logic [31:0] rec_b [$];
  logic [31:0] rec_c [$];

  byte_beat_t  bytes_q [$];
  word_beat_t  words_q [$];
  string       test_name;
  int          mode;
  int          clear_at;
  bit          collect_done;
  bit          released;
  logic [15:0] lfsr = 16'd67;
  int          value_errors = 0;
  int          other_errors = 0;
  int          cycles = 0;
  int          cycle_limit = 100000;

  pack_top #(
    .in_depth_w(IN_DEPTH_W),
    .out_depth_w(OUT_DEPTH_W)
  ) DUT (
    .clk(clk),
    .anrst(anrst),
    .nrst(nrst),
    .in_data(in_data),
    .in_last(in_last),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .out_data(out_data),
    .out_nbytes(out_nbytes),
    .out_last(out_last),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles in test %s", cycles, test_name);
      $display("Errors found");
      $finish;
    end
  end

  // Taps 16, 14, 13 and 11.
  function automatic int random_bits(input int n);
    int value;
    value = 0;
    for (int k = 0; k < n; k++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      value = (value << 1) | int'(lfsr[0]);
    end
    return value;
  endfunction

  task automatic check_word(input string name, input word_beat_t exp, input word_beat_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected data=%h nbytes=%0d last=%b, actual data=%h nbytes=%0d last=%b",
               name, exp.data, exp.nbytes, exp.last, act.data, act.nbytes, act.last);
      value_errors++;
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic load_patterns();
    int    fd;
    int    code;
    int    want;
    int    a;
    int    b;
    int    c;
    string tag;
    string name;
    string rest;
    fd = $fopen("dv/pack_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file dv/pack_patterns.txt");
      other_errors++;
    end else begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        a = 0;
        b = 0;
        c = 0;
        name = "";
        code = 0;
        want = 0;
        if (tag.substr(0, 0) == "#") begin
          code = $fgets(rest, fd); // Skip the rest of a comment line.
        end else begin
          if (tag == "P") begin
            code = $fscanf(fd, "%s %h", name, a);
            want = 2;
          end else if (tag == "B") begin
            code = $fscanf(fd, "%h %h", a, b);
            want = 2;
          end else if (tag == "W") begin
            code = $fscanf(fd, "%h %h %h", a, b, c);
            want = 3;
          end else if (tag != "C") begin
            $display("Unknown tag %s in the pattern file", tag);
            other_errors++;
          end
          if (code != want) begin
            $display("Incomplete %s line in the pattern file", tag);
            other_errors++;
          end
          rec_kind.push_back(tag);
          rec_name.push_back(name);
          rec_a.push_back(a);
          rec_b.push_back(b);
          rec_c.push_back(c);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_bytes(input int first, input int stop);
    int gap;
    bit accepted;
    for (int i = first; i < stop; i++) begin
      if (mode == mode_random) begin
        gap = random_bits(2);
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
      in_valid = 1'b1;
      in_data = bytes_q[i].data;
      in_last = bytes_q[i].last;
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = in_ready; // The edge that follows completes the handshake.
        @(posedge clk);
        #1;
      end
      in_valid = 1'b0;
    end
  endtask

  task automatic collect_words();
    word_beat_t got;
    int         idx;
    int         idle;
    idx = 0;
    idle = 0;
    while (idx < words_q.size() && idle < word_wait) begin
      @(negedge clk);
      if (out_valid && out_ready) begin
        got.data = out_data;
        got.nbytes = out_nbytes;
        got.last = out_last;
        check_word(test_name, words_q[idx], got);
        idx++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (idx < words_q.size()) begin
      $display("Test %s is missing %0d of %0d words", test_name, words_q.size() - idx,
               words_q.size());
      other_errors++;
    end
  endtask

  task automatic drive_out_ready();
    while (!collect_done) begin
      if (mode == mode_random) begin
        out_ready = (random_bits(2) != 0);
      end else begin
        out_ready = released;
      end
      @(posedge clk);
      #1;
    end
    out_ready = 1'b1;
  endtask

  // Output held back, so input must stall once every buffer is full.
  task automatic wait_full();
    int n;
    n = 0;
    while (in_ready && n < word_wait) begin
      @(negedge clk);
      n++;
    end
    check_ready({test_name, " in_ready when full"}, 1'b0, in_ready);
    released = 1'b1;
  endtask

  // The clear lands while the last byte still sits in the input FIFO.
  task automatic clear_section();
    int n;
    out_ready = 1'b0;
    drive_bytes(0, clear_at);
    n = 0;
    while (!out_valid && n < 50) begin
      @(negedge clk);
      n++;
    end
    check_ready({test_name, " word buffered before clear"}, 1'b1, out_valid);
    nrst = 1'b0;
    @(posedge clk);
    #1;
    nrst = 1'b1;
    @(negedge clk);
    check_ready({test_name, " out_valid after clear"}, 1'b0, out_valid);
    check_ready({test_name, " in_ready after clear"}, 1'b1, in_ready);
    @(posedge clk);
    #1;
  endtask

  task automatic flag_extra_words();
    bit seen;
    seen = 1'b0;
    repeat (8) begin
      @(negedge clk);
      if (out_valid) begin
        seen = 1'b1;
      end
    end
    if (seen) begin
      $display("Test %s produced more words than expected", test_name);
      other_errors++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic run_section();
    int start;
    start = 0;
    if (mode == mode_clear && clear_at >= 0) begin
      clear_section();
      start = clear_at;
    end
    collect_done = 1'b0;
    released = (mode != mode_bp);
    fork
      drive_bytes(start, bytes_q.size());
      begin
        collect_words();
        collect_done = 1'b1;
      end
      drive_out_ready();
      begin
        if (mode == mode_bp) begin
          wait_full();
        end
      end
    join
    flag_extra_words();
  endtask

  initial begin
    int         i;
    byte_beat_t bb;
    word_beat_t wb;
    anrst = 1'b0;
    nrst = 1'b1;
    in_data = '0;
    in_last = 1'b0;
    in_valid = 1'b0;
    out_ready = 1'b0;
    test_name = "reset";
    load_patterns();
    cycle_limit = 20 * rec_kind.size() + 200;
    repeat (16) @(posedge clk);
    #1;
    check_ready("reset out_valid", 1'b0, out_valid);
    check_ready("reset in_ready", 1'b1, in_ready);
    anrst = 1'b1;
    @(posedge clk);
    #1;
    check_ready("after reset out_valid", 1'b0, out_valid);
    check_ready("after reset in_ready", 1'b1, in_ready);
    i = 0;
    while (i < rec_kind.size()) begin
      test_name = rec_name[i]; // Every section opens with a P line.
      mode = int'(rec_a[i]);
      bytes_q.delete();
      words_q.delete();
      clear_at = -1;
      i++;
      while (i < rec_kind.size() && rec_kind[i] != "P") begin
        if (rec_kind[i] == "B") begin
          bb.data = rec_a[i][7:0];
          bb.last = rec_b[i][0];
          bytes_q.push_back(bb);
        end else if (rec_kind[i] == "W") begin
          wb.data = rec_a[i];
          wb.nbytes = rec_b[i][2:0];
          wb.last = rec_c[i][0];
          words_q.push_back(wb);
        end else if (rec_kind[i] == "C") begin
          clear_at = bytes_q.size();
        end
        i++;
      end
      run_section();
    end
    $display("Summary: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- dv/pack_patterns.txt
# Columns: P name mode | B data last | W data nbytes last | C marks a sync clear. Hex values.
# Modes: 0 streaming, 1 back-pressure, 2 clear mid-packet, 3 random gaps and stalls.
P full_words 0
B 11 0
B 22 0
B 33 0
B 44 0
W 44332211 4 0
B a0 0
B b1 0
B c2 0
B d3 1
W d3c2b1a0 4 1
P short_packets 0
B 5a 1
W 0000005a 1 1
B 01 0
B 02 1
W 00000201 2 1
B e1 0
B e2 0
B e3 1
W 00e3e2e1 3 1
P backpressure 1
B 80 0
B 81 0
B 82 0
B 83 0
W 83828180 4 0
B 84 0
B 85 0
B 86 0
B 87 0
W 87868584 4 0
B 88 0
B 89 0
B 8a 0
B 8b 0
W 8b8a8988 4 0
B 8c 0
B 8d 0
B 8e 0
B 8f 0
W 8f8e8d8c 4 0
B 90 0
B 91 0
B 92 0
B 93 0
W 93929190 4 0
B 94 0
B 95 0
B 96 0
B 97 0
W 97969594 4 0
B 98 0
B 99 0
B 9a 0
B 9b 0
W 9b9a9998 4 0
B 9c 0
B 9d 0
B 9e 0
B 9f 0
W 9f9e9d9c 4 0
B a0 0
B a1 0
B a2 0
B a3 0
W a3a2a1a0 4 0
B a4 0
B a5 0
B a6 0
B a7 1
W a7a6a5a4 4 1
P sync_clear 2
B 61 0
B 62 0
B 63 0
B 64 0
B 65 0
B 66 0
C
B 71 0
B 72 0
B 73 0
B 74 1
W 74737271 4 1
P random_stalls 3
B 10 0
B 11 0
B 12 0
B 13 0
W 13121110 4 0
B 20 0
B 21 1
W 00002120 2 1
B 30 1
W 00000030 1 1
B 40 0
B 41 0
B 42 0
B 43 0
W 43424140 4 0
B 44 0
B 45 0
B 46 1
W 00464544 3 1
B 50 0
B 51 0
B 52 0
B 53 1
W 53525150 4 1

//--- verilog.f
verilog/pack_pkg.sv
verilog/stream_fifo.sv
verilog/byte_packer.sv
verilog/pack_top.sv
dv/pack_checker.sv
dv/pack_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := pack_tb
FILELIST   := verilog.f
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := No errors

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
